// ==== design/cache_cfg.svh ====
/* geometry of the 2-way data cache
   included by both packages and by the RTL that sizes arrays from it */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// byte address and word
`define CACHE_ADDR_WIDTH 16
`define CACHE_DATA_WIDTH 32
`define CACHE_SEL_WIDTH 4

// sets per way and words per line, ways are fixed at two
`define CACHE_SETS 16
`define CACHE_LINE_WORDS 4

`endif

// ==== design/cache_pkg.sv ====
/* address field, way and front-end state types of the cache
   referenced by scoped name from the RTL */
`include "cache_cfg.svh"

package cache_pkg;

  // field positions within a byte address
  localparam int byte_width_lp = $clog2(`CACHE_SEL_WIDTH);
  localparam int offset_width_lp = $clog2(`CACHE_LINE_WORDS);
  localparam int index_width_lp = $clog2(`CACHE_SETS);
  localparam int index_lsb_lp = byte_width_lp + offset_width_lp;
  localparam int tag_lsb_lp = index_lsb_lp + index_width_lp;
  localparam int tag_width_lp = `CACHE_ADDR_WIDTH - tag_lsb_lp;

  typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`CACHE_DATA_WIDTH-1:0] word_t;
  typedef logic [`CACHE_SEL_WIDTH-1:0] sel_t;
  typedef logic [tag_width_lp-1:0] tag_t;
  typedef logic [index_width_lp-1:0] index_t;
  typedef logic [offset_width_lp-1:0] offset_t;
  typedef logic way_t;

  typedef enum logic [1:0] {
    e_front_idle,
    e_front_lookup,
    e_front_compare,
    e_front_miss_wait
  } front_state_e;

endpackage

// ==== design/refill_pkg.sv ====
/* memory-side types of the miss sequencer */
`include "cache_cfg.svh"

package refill_pkg;

  // a line address is the byte address without offset and byte bits
  localparam int line_width_lp = `CACHE_ADDR_WIDTH - $clog2(`CACHE_LINE_WORDS)
    - $clog2(`CACHE_SEL_WIDTH);

  typedef logic [line_width_lp-1:0] line_addr_t;
  typedef logic [$clog2(`CACHE_LINE_WORDS)-1:0] word_count_t;

  typedef enum logic [2:0] {
    e_miss_idle,
    e_miss_evict,
    e_miss_refill,
    e_miss_install,
    e_miss_done
  } miss_state_e;

endpackage

// ==== design/cache_tag_store.sv ====
/* tag, valid, dirty and lru state of both ways
   read on lookup, compared in the following cycle, updated on hit or install */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tag_store (
  input  logic clk_i,
  input  logic reset_i,
  output logic init_busy_o,
  input  logic lookup_i,
  input  cache_pkg::addr_t lookup_addr_i,
  output logic hit_o,
  output cache_pkg::way_t hit_way_o,
  output cache_pkg::way_t victim_way_o,
  output logic victim_dirty_o,
  output cache_pkg::tag_t victim_tag_o,
  input  logic touch_i,
  input  logic mark_dirty_i,
  input  logic install_i,
  input  cache_pkg::way_t install_way_i
);

  cache_pkg::tag_t tag_mem [2][`CACHE_SETS];
  logic [1:0] valid_mem [`CACHE_SETS];
  logic [1:0] dirty_mem [`CACHE_SETS];
  cache_pkg::way_t lru_mem [`CACHE_SETS];

  cache_pkg::tag_t tag_rd_q [2];
  logic [1:0] valid_rd_q;
  logic [1:0] dirty_rd_q;
  cache_pkg::way_t lru_rd_q;
  cache_pkg::tag_t req_tag_q;
  cache_pkg::index_t req_index_q;

  logic init_busy_q;
  cache_pkg::index_t init_index_q;
  cache_pkg::index_t lookup_index;
  logic [1:0] way_hit;

  assign lookup_index = lookup_addr_i[cache_pkg::index_lsb_lp +: cache_pkg::index_width_lp];

  // synchronous read of one set, tag kept for the compare cycle
  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      for (int w = 0; w < 2; w++) begin
        tag_rd_q[w] <= tag_mem[w][lookup_index];
      end
      valid_rd_q <= valid_mem[lookup_index];
      dirty_rd_q <= dirty_mem[lookup_index];
      lru_rd_q <= lru_mem[lookup_index];
      req_tag_q <= lookup_addr_i[cache_pkg::tag_lsb_lp +: cache_pkg::tag_width_lp];
      req_index_q <= lookup_index;
    end
  end

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = valid_rd_q[w] & (tag_rd_q[w] == req_tag_q);
    end
  end

  assign hit_o = |way_hit;
  assign hit_way_o = way_hit[1];

  // invalid ways first, then the lru way
  always_comb begin
    if (!valid_rd_q[0])
      victim_way_o = 1'b0;
    else if (!valid_rd_q[1])
      victim_way_o = 1'b1;
    else
      victim_way_o = lru_rd_q;
  end

  assign victim_dirty_o = valid_rd_q[victim_way_o] & dirty_rd_q[victim_way_o];
  assign victim_tag_o = tag_rd_q[victim_way_o];

  // walk all sets after reset to clear the metadata
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      init_busy_q <= 1'b1;
      init_index_q <= '0;
    end else if (init_busy_q) begin
      init_index_q <= init_index_q + 1'b1;
      if (init_index_q == cache_pkg::index_t'(`CACHE_SETS - 1))
        init_busy_q <= 1'b0;
    end
  end

  assign init_busy_o = init_busy_q;

  always_ff @(posedge clk_i) begin
    if (init_busy_q) begin
      valid_mem[init_index_q] <= 2'b00;
      dirty_mem[init_index_q] <= 2'b00;
      lru_mem[init_index_q] <= 1'b0;
    end else begin
      // a hit points lru at the other way
      if (touch_i) begin
        lru_mem[req_index_q] <= ~hit_way_o;
        if (mark_dirty_i)
          dirty_mem[req_index_q][hit_way_o] <= 1'b1;
      end
      if (install_i) begin
        tag_mem[install_way_i][req_index_q] <= req_tag_q;
        valid_mem[req_index_q][install_way_i] <= 1'b1;
        dirty_mem[req_index_q][install_way_i] <= 1'b0;
      end
    end
  end

endmodule

// ==== design/cache_data_store.sv ====
/* line data of both ways, one word per access
   both ways are read together, a write goes to one way under byte selects */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_data_store (
  input  logic clk_i,
  input  logic rd_i,
  input  logic wr_i,
  input  cache_pkg::way_t way_i,
  input  cache_pkg::index_t index_i,
  input  cache_pkg::offset_t offset_i,
  input  cache_pkg::sel_t sel_i,
  input  cache_pkg::word_t wdata_i,
  output cache_pkg::word_t [1:0] rdata_o
);

  localparam int depth_lp = `CACHE_SETS * `CACHE_LINE_WORDS;

  cache_pkg::word_t mem [2][depth_lp];
  logic [$clog2(depth_lp)-1:0] addr;

  assign addr = {index_i, offset_i};

  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      for (int b = 0; b < `CACHE_SEL_WIDTH; b++) begin
        if (sel_i[b])
          mem[way_i][addr][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // output holds until the next read
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      for (int w = 0; w < 2; w++) begin
        rdata_o[w] <= mem[w][addr];
      end
    end
  end

endmodule

// ==== design/cache_miss_unit.sv ====
/* miss sequencer, Wishbone classic master on the memory side
   writes back a dirty victim, refills the line word by word, then installs the tag */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_miss_unit (
  input  logic clk_i,
  input  logic reset_i,
  input  logic miss_start_i,
  input  cache_pkg::addr_t miss_addr_i,
  input  cache_pkg::way_t victim_way_i,
  input  logic victim_dirty_i,
  input  cache_pkg::tag_t victim_tag_i,
  output logic mem_cyc_o,
  output logic mem_stb_o,
  output logic mem_we_o,
  output cache_pkg::addr_t mem_adr_o,
  output cache_pkg::word_t mem_dat_o,
  input  cache_pkg::word_t mem_dat_i,
  input  logic mem_ack_i,
  output logic dmem_rd_o,
  output logic dmem_wr_o,
  output cache_pkg::way_t dmem_way_o,
  output cache_pkg::offset_t dmem_offset_o,
  output cache_pkg::word_t dmem_wdata_o,
  input  cache_pkg::word_t dmem_rdata_i,
  output logic install_o,
  output logic miss_done_o
);

  refill_pkg::miss_state_e state_q;
  refill_pkg::word_count_t count_q;
  logic stb_q;

  refill_pkg::line_addr_t line_q;
  cache_pkg::tag_t victim_tag_q;
  cache_pkg::way_t way_q;

  refill_pkg::line_addr_t beat_line;
  logic start;
  logic beat_ack;
  logic last_beat;

  assign start = (state_q == refill_pkg::e_miss_idle) & miss_start_i;
  assign beat_ack = stb_q & mem_ack_i;
  assign last_beat = (count_q == refill_pkg::word_count_t'(`CACHE_LINE_WORDS - 1));

  always_ff @(posedge clk_i) begin
    if (start) begin
      line_q <= miss_addr_i[cache_pkg::index_lsb_lp +: refill_pkg::line_width_lp];
      victim_tag_q <= victim_tag_i;
      way_q <= victim_way_i;
    end
  end

  // victim line keeps the set index of the missing line
  assign beat_line = (state_q == refill_pkg::e_miss_evict)
    ? {victim_tag_q, line_q[cache_pkg::index_width_lp-1:0]}
    : line_q;

  // one classic cycle per beat, stb dropped for a cycle after each ack
  assign mem_cyc_o = stb_q;
  assign mem_stb_o = stb_q;
  assign mem_we_o = stb_q & (state_q == refill_pkg::e_miss_evict);
  assign mem_adr_o = {beat_line, count_q, {cache_pkg::byte_width_lp{1'b0}}};
  assign mem_dat_o = dmem_rdata_i;

  // victim words are fetched one cycle ahead of their write beat
  always_comb begin
    dmem_rd_o = 1'b0;
    dmem_wr_o = 1'b0;
    dmem_offset_o = count_q;
    if (start && victim_dirty_i) begin
      dmem_rd_o = 1'b1;
      dmem_offset_o = '0;
    end else if (state_q == refill_pkg::e_miss_evict && beat_ack && !last_beat) begin
      dmem_rd_o = 1'b1;
      dmem_offset_o = count_q + 1'b1;
    end else if (state_q == refill_pkg::e_miss_refill && beat_ack) begin
      dmem_wr_o = 1'b1;
    end
  end

  assign dmem_way_o = way_q;
  assign dmem_wdata_o = mem_dat_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= refill_pkg::e_miss_idle;
      count_q <= '0;
      stb_q <= 1'b0;
    end else begin
      case (state_q)
        refill_pkg::e_miss_idle: begin
          if (miss_start_i) begin
            state_q <= victim_dirty_i ? refill_pkg::e_miss_evict : refill_pkg::e_miss_refill;
            count_q <= '0;
            stb_q <= 1'b1;
          end
        end
        refill_pkg::e_miss_evict, refill_pkg::e_miss_refill: begin
          if (beat_ack) begin
            stb_q <= 1'b0;
            // counter wraps to zero after the last beat
            count_q <= count_q + 1'b1;
            if (last_beat)
              state_q <= (state_q == refill_pkg::e_miss_evict)
                ? refill_pkg::e_miss_refill : refill_pkg::e_miss_install;
          end else if (!stb_q) begin
            stb_q <= 1'b1;
          end
        end
        refill_pkg::e_miss_install: state_q <= refill_pkg::e_miss_done;
        default: state_q <= refill_pkg::e_miss_idle;
      endcase
    end
  end

  assign install_o = (state_q == refill_pkg::e_miss_install);
  assign miss_done_o = (state_q == refill_pkg::e_miss_done);

endmodule

// ==== design/cache_top.sv ====
/* 2-way write-back data cache, Wishbone classic slave towards the processor
   a request is looked up, compared, and on a miss replayed after the refill */
`timescale 1ns/1ps

module cache_top (
  input  logic clk_i,
  input  logic reset_i,
  input  logic wb_cyc_i,
  input  logic wb_stb_i,
  input  logic wb_we_i,
  input  cache_pkg::addr_t wb_adr_i,
  input  cache_pkg::word_t wb_dat_i,
  input  cache_pkg::sel_t wb_sel_i,
  output cache_pkg::word_t wb_dat_o,
  output logic wb_ack_o,
  output logic mem_cyc_o,
  output logic mem_stb_o,
  output logic mem_we_o,
  output cache_pkg::addr_t mem_adr_o,
  output cache_pkg::word_t mem_dat_o,
  input  cache_pkg::word_t mem_dat_i,
  input  logic mem_ack_i
);

  cache_pkg::front_state_e state_q;
  cache_pkg::addr_t req_addr_q;
  cache_pkg::word_t req_dat_q;
  cache_pkg::sel_t req_sel_q;
  logic req_we_q;

  logic init_busy;
  logic start;
  logic lookup;
  cache_pkg::addr_t lookup_addr;
  logic hit;
  logic ack;
  cache_pkg::way_t hit_way;
  cache_pkg::way_t victim_way;
  logic victim_dirty;
  cache_pkg::tag_t victim_tag;

  logic miss_start;
  logic miss_done;
  logic install;
  logic miss_rd;
  logic miss_wr;
  cache_pkg::way_t miss_way;
  cache_pkg::offset_t miss_offset;
  cache_pkg::word_t miss_wdata;

  logic ds_rd;
  logic ds_wr;
  cache_pkg::way_t ds_way;
  cache_pkg::offset_t ds_offset;
  cache_pkg::sel_t ds_sel;
  cache_pkg::word_t ds_wdata;
  cache_pkg::word_t [1:0] ds_rdata;

  // requests wait while the tag store clears itself
  assign start = (state_q == cache_pkg::e_front_idle) & wb_cyc_i & wb_stb_i & ~init_busy;
  assign lookup = start | (state_q == cache_pkg::e_front_lookup);
  assign lookup_addr = (state_q == cache_pkg::e_front_idle) ? wb_adr_i : req_addr_q;

  assign ack = (state_q == cache_pkg::e_front_compare) & hit;
  assign miss_start = (state_q == cache_pkg::e_front_compare) & ~hit;
  assign wb_ack_o = ack;
  assign wb_dat_o = ds_rdata[hit_way];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= cache_pkg::e_front_idle;
    end else begin
      case (state_q)
        cache_pkg::e_front_idle: begin
          if (start)
            state_q <= cache_pkg::e_front_lookup;
        end
        cache_pkg::e_front_lookup: state_q <= cache_pkg::e_front_compare;
        cache_pkg::e_front_compare: begin
          state_q <= hit ? cache_pkg::e_front_idle : cache_pkg::e_front_miss_wait;
        end
        default: begin
          // replay the request once the line is in
          if (miss_done)
            state_q <= cache_pkg::e_front_lookup;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      req_addr_q <= wb_adr_i;
      req_dat_q <= wb_dat_i;
      req_sel_q <= wb_sel_i;
      req_we_q <= wb_we_i;
    end
  end

  // the miss unit owns the data store whenever it accesses it
  always_comb begin
    if (miss_rd | miss_wr) begin
      ds_rd = miss_rd;
      ds_wr = miss_wr;
      ds_way = miss_way;
      ds_offset = miss_offset;
      ds_sel = '1;
      ds_wdata = miss_wdata;
    end else begin
      ds_rd = lookup;
      ds_wr = ack & req_we_q;
      ds_way = hit_way;
      ds_offset = lookup_addr[cache_pkg::byte_width_lp +: cache_pkg::offset_width_lp];
      ds_sel = req_sel_q;
      ds_wdata = req_dat_q;
    end
  end

  cache_tag_store tags (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .init_busy_o(init_busy),
    .lookup_i(lookup),
    .lookup_addr_i(lookup_addr),
    .hit_o(hit),
    .hit_way_o(hit_way),
    .victim_way_o(victim_way),
    .victim_dirty_o(victim_dirty),
    .victim_tag_o(victim_tag),
    .touch_i(ack),
    .mark_dirty_i(req_we_q),
    .install_i(install),
    .install_way_i(miss_way)
  );

  cache_data_store data (
    .clk_i(clk_i),
    .rd_i(ds_rd),
    .wr_i(ds_wr),
    .way_i(ds_way),
    .index_i(lookup_addr[cache_pkg::index_lsb_lp +: cache_pkg::index_width_lp]),
    .offset_i(ds_offset),
    .sel_i(ds_sel),
    .wdata_i(ds_wdata),
    .rdata_o(ds_rdata)
  );

  cache_miss_unit miss (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .miss_start_i(miss_start),
    .miss_addr_i(req_addr_q),
    .victim_way_i(victim_way),
    .victim_dirty_i(victim_dirty),
    .victim_tag_i(victim_tag),
    .mem_cyc_o(mem_cyc_o),
    .mem_stb_o(mem_stb_o),
    .mem_we_o(mem_we_o),
    .mem_adr_o(mem_adr_o),
    .mem_dat_o(mem_dat_o),
    .mem_dat_i(mem_dat_i),
    .mem_ack_i(mem_ack_i),
    .dmem_rd_o(miss_rd),
    .dmem_wr_o(miss_wr),
    .dmem_way_o(miss_way),
    .dmem_offset_o(miss_offset),
    .dmem_wdata_o(miss_wdata),
    .dmem_rdata_i(ds_rdata[miss_way]),
    .install_o(install),
    .miss_done_o(miss_done)
  );

endmodule

// ==== bench/mem_model.sv ====
/* backing memory of the cache testbench, a Wishbone classic slave
   each word starts as its byte address times 3, acks come after delay_i wait cycles */
`timescale 1ns/1ps

module mem_model (
  input  logic clk_i,
  input  logic reset_i,
  input  logic [1:0] delay_i,
  input  logic cyc_i,
  input  logic stb_i,
  input  logic we_i,
  input  cache_pkg::addr_t adr_i,
  input  cache_pkg::word_t dat_i,
  output cache_pkg::word_t dat_o,
  output logic ack_o
);

  localparam int words_lp = 2 ** ($bits(cache_pkg::addr_t) - 2);

  cache_pkg::word_t mem [words_lp];
  logic [1:0] wait_q;

  initial begin
    for (int i = 0; i < words_lp; i++) begin
      mem[i] = cache_pkg::word_t'(i) * 12;
    end
  end

  // one ack per transfer, the master drops stb in the cycle after it
  always @(posedge clk_i) begin
    if (reset_i) begin
      ack_o <= 1'b0;
      wait_q <= '0;
    end else if (ack_o) begin
      ack_o <= 1'b0;
    end else if (cyc_i && stb_i) begin
      if (wait_q >= delay_i) begin
        ack_o <= 1'b1;
        wait_q <= '0;
        if (we_i)
          mem[adr_i >> 2] <= dat_i;
        else
          dat_o <= mem[adr_i >> 2];
      end else begin
        wait_q <= wait_q + 1'b1;
      end
    end
  end

endmodule

// ==== bench/cache_tb.sv ====
/* directed and random tests of the 2-way data cache
   a reference word array follows every store and every memory beat is logged and checked */
`timescale 1ns/1ps

module cache_tb;

  localparam int words_lp = 2 ** ($bits(cache_pkg::addr_t) - 2);
  // each of the 220 accesses takes at most 8 beats of 6 cycles plus about 16 more
  // and reset with the tag clearing walk adds a few
  localparam int timeout_cycles_lp = 220 * 64 + 32;

  logic clk;
  logic reset;
  logic wb_cyc, wb_stb, wb_we, wb_ack;
  cache_pkg::addr_t wb_adr;
  cache_pkg::word_t wb_wdat, wb_rdat;
  cache_pkg::sel_t wb_sel;
  logic mem_cyc, mem_stb, mem_we, mem_ack;
  cache_pkg::addr_t mem_adr;
  cache_pkg::word_t mem_wdat, mem_rdat;
  logic [1:0] mem_delay;

  cache_pkg::word_t ref_mem [words_lp];
  cache_pkg::addr_t beat_adr [$];
  logic beat_we [$];
  cache_pkg::word_t beat_dat [$];

  int errors = 0;
  int checks = 0;
  int cycle_count = 0;
  integer seed = 32'h88ac;

  cache_top uut (
    .clk_i(clk),
    .reset_i(reset),
    .wb_cyc_i(wb_cyc),
    .wb_stb_i(wb_stb),
    .wb_we_i(wb_we),
    .wb_adr_i(wb_adr),
    .wb_dat_i(wb_wdat),
    .wb_sel_i(wb_sel),
    .wb_dat_o(wb_rdat),
    .wb_ack_o(wb_ack),
    .mem_cyc_o(mem_cyc),
    .mem_stb_o(mem_stb),
    .mem_we_o(mem_we),
    .mem_adr_o(mem_adr),
    .mem_dat_o(mem_wdat),
    .mem_dat_i(mem_rdat),
    .mem_ack_i(mem_ack)
  );

  mem_model mem (
    .clk_i(clk),
    .reset_i(reset),
    .delay_i(mem_delay),
    .cyc_i(mem_cyc),
    .stb_i(mem_stb),
    .we_i(mem_we),
    .adr_i(mem_adr),
    .dat_i(mem_wdat),
    .dat_o(mem_rdat),
    .ack_o(mem_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles_lp) begin
      $display("timeout after %0d cycles, a request was never acknowledged", cycle_count);
      $display("%0d errors in %0d checks", errors, checks);
      $display("tests failed");
      $finish;
    end
  end

  // log every memory beat at its ack
  always @(negedge clk) begin
    if (mem_cyc && mem_stb && mem_ack) begin
      beat_adr.push_back(mem_adr);
      beat_we.push_back(mem_we);
      beat_dat.push_back(mem_wdat);
    end
  end

  function automatic cache_pkg::word_t merge_bytes(cache_pkg::word_t old_w,
      cache_pkg::word_t new_w, cache_pkg::sel_t sel);
    cache_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < $bits(cache_pkg::sel_t); b++) begin
      if (sel[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic cache_pkg::addr_t line_addr(logic [7:0] tag, logic [3:0] index);
    return {tag, index, 4'b0000};
  endfunction

  task automatic clear_beats();
    beat_adr.delete();
    beat_we.delete();
    beat_dat.delete();
  endtask

  // one classic cycle where edges counts rising edges from the request edge to the ack edge
  task automatic bus_access(input logic we, input cache_pkg::addr_t adr,
      input cache_pkg::word_t dat, input cache_pkg::sel_t sel,
      output cache_pkg::word_t rdata, output int edges);
    int n;
    n = 0;
    @(posedge clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_wdat = dat;
    wb_sel = sel;
    do begin
      @(negedge clk);
      n++;
    end while (wb_ack !== 1'b1);
    rdata = wb_rdat;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    // the first falling edge comes before the request edge
    edges = n - 1;
  endtask

  task automatic read_word(input cache_pkg::addr_t adr, input int exp_edges);
    cache_pkg::word_t got;
    cache_pkg::word_t exp;
    int edges;
    exp = ref_mem[adr >> 2];
    bus_access(1'b0, adr, '0, '1, got, edges);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t wb_dat_o got %h expected %h at address %h", $time, got, exp, adr);
    end
    if (exp_edges >= 0) begin
      checks++;
      assert (edges == exp_edges) else begin
        errors++;
        $display("read of %h was acknowledged %0d edges after the request instead of %0d",
          adr, edges, exp_edges);
      end
    end
  endtask

  task automatic write_word(input cache_pkg::addr_t adr, input cache_pkg::word_t dat,
      input cache_pkg::sel_t sel);
    cache_pkg::word_t unused;
    int edges;
    ref_mem[adr >> 2] = merge_bytes(ref_mem[adr >> 2], dat, sel);
    bus_access(1'b1, adr, dat, sel, unused, edges);
    // ack lasts one cycle only
    checks++;
    assert (wb_ack === 1'b0) else begin
      errors++;
      $display("FAIL %0t wb_ack_o got %b expected 0", $time, wb_ack);
    end
  endtask

  // four beats of one line at offsets 0 to 3 whose write data must match the reference
  task automatic expect_mem_beats(input cache_pkg::addr_t line_base, input logic we);
    cache_pkg::addr_t exp_adr;
    cache_pkg::addr_t adr;
    logic got_we;
    cache_pkg::word_t dat;
    for (int i = 0; i < 4; i++) begin
      exp_adr = line_base + cache_pkg::addr_t'(4 * i);
      checks++;
      assert (beat_adr.size() > 0) else begin
        errors++;
        $display("memory beat to %h never happened", exp_adr);
      end
      if (beat_adr.size() > 0) begin
        adr = beat_adr.pop_front();
        got_we = beat_we.pop_front();
        dat = beat_dat.pop_front();
        checks++;
        assert (adr === exp_adr) else begin
          errors++;
          $display("FAIL %0t mem_adr_o got %h expected %h", $time, adr, exp_adr);
        end
        checks++;
        assert (got_we === we) else begin
          errors++;
          $display("FAIL %0t mem_we_o got %b expected %b", $time, got_we, we);
        end
        if (we) begin
          checks++;
          assert (dat === ref_mem[exp_adr >> 2]) else begin
            errors++;
            $display("FAIL %0t mem_dat_o got %h expected %h", $time, dat, ref_mem[exp_adr >> 2]);
          end
        end
      end
    end
  endtask

  task automatic expect_no_beats();
    checks++;
    assert (beat_adr.size() == 0) else begin
      errors++;
      $display("%0d unexpected memory beats before %0t", beat_adr.size(), $time);
    end
    clear_beats();
  endtask

  task automatic reset_state_and_read_miss();
    checks++;
    assert (wb_ack === 1'b0 && mem_cyc === 1'b0 && mem_stb === 1'b0 && mem_we === 1'b0)
    else begin
      errors++;
      $display("FAIL %0t wb_ack_o/mem_cyc_o/mem_stb_o/mem_we_o got %b/%b/%b/%b expected 0/0/0/0",
        $time, wb_ack, mem_cyc, mem_stb, mem_we);
    end
    mem_delay = 2'd1;
    read_word(16'h0104, -1);
    expect_mem_beats(16'h0100, 1'b0);
    expect_no_beats();
  endtask

  task automatic read_hits_same_line();
    for (int o = 3; o >= 0; o--) begin
      read_word(16'h0100 + cache_pkg::addr_t'(4 * o), 2);
    end
    expect_no_beats();
  endtask

  task automatic byte_select_stores();
    write_word(16'h0108, 32'hA1B2C3D4, 4'b0101);
    read_word(16'h0108, 2);
    write_word(16'h010C, 32'h5E6F7788, 4'b1000);
    read_word(16'h010C, 2);
    write_word(16'h0100, 32'h0BADF00D, 4'b0110);
    read_word(16'h0100, 2);
    expect_no_beats();
  endtask

  // lines a to d share set 5
  task automatic lru_eviction_writeback();
    cache_pkg::addr_t a, b, c, d;
    a = line_addr(8'h10, 4'd5);
    b = line_addr(8'h20, 4'd5);
    c = line_addr(8'h30, 4'd5);
    d = line_addr(8'h40, 4'd5);
    mem_delay = 2'd2;
    write_word(a + 4, 32'hCAFE0001, 4'b1111);
    expect_mem_beats(a, 1'b0);
    expect_no_beats();
    read_word(b, -1);
    expect_mem_beats(b, 1'b0);
    expect_no_beats();
    // b becomes the lru way
    read_word(a + 4, 2);
    expect_no_beats();
    // clean b goes without write beats
    read_word(c + 8, -1);
    expect_mem_beats(c, 1'b0);
    expect_no_beats();
    read_word(d, -1);
    expect_mem_beats(a, 1'b1);
    expect_mem_beats(d, 1'b0);
    expect_no_beats();
    // the stored word now comes back from memory
    read_word(a + 4, -1);
    expect_mem_beats(a, 1'b0);
    expect_no_beats();
  endtask

  task automatic random_sequence();
    logic [31:0] r;
    cache_pkg::word_t dat;
    cache_pkg::addr_t adr;
    for (int n = 0; n < 200; n++) begin
      r = $random(seed);
      dat = $random(seed);
      mem_delay = r[7:6];
      // four tags over sets 8 to 11 so four lines fight for two ways
      adr = {6'b011000, r[3:2], 2'b10, r[1:0], r[5:4], 2'b00};
      if (r[8])
        write_word(adr, dat, r[12:9]);
      else
        read_word(adr, -1);
      clear_beats();
    end
  endtask

  initial begin
    for (int i = 0; i < words_lp; i++) begin
      ref_mem[i] = cache_pkg::word_t'(i * 4) * 3;
    end
    reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_wdat = '0;
    wb_sel = '0;
    mem_delay = 2'd0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    reset_state_and_read_miss();
    read_hits_same_line();
    byte_select_stores();
    lru_eviction_writeback();
    random_sequence();

    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+design
design/cache_pkg.sv
design/refill_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_miss_unit.sv
design/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache_2way

sources:
  - include_dirs:
      - design
    files:
      - design/cache_pkg.sv
      - design/refill_pkg.sv
      - design/cache_tag_store.sv
      - design/cache_data_store.sv
      - design/cache_miss_unit.sv
      - design/cache_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/mem_model.sv
      - bench/cache_tb.sv
